//--- flist.f
+incdir+src
src/rv32m_pkg.sv
src/md_pkg.sv
src/md_control.sv
src/md_step_counter.sv
src/md_divider.sv
src/md_multiplier.sv
src/md_unit.sv
tb/md_unit_assertions.sv
tb/md_unit_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
TOP      := md_unit_tb
FLIST    := flist.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb/md_unit_tb.sv
`timescale 1ns/10ps
`include "md_macros.svh"

module md_unit_tb import md_pkg::*, rv32m_pkg::*; ();

    typedef logic [`MD_XLEN-1:0]          word_t;
    typedef logic [`MD_PHYS_REG_BITS-1:0] tag_t;

    localparam int RESET_CYCLES = 10;
    localparam int LATENCY      = 34; // start cycle to valid cycle, for every operation.
    localparam int N_EDGE       = 8 * 5 * 5;
    localparam int N_RANDOM     = 200;
    localparam int N_OPS        = N_EDGE + N_RANDOM + 3; // the dropped start test weighs three.

    logic       clk;
    logic       rst;
    logic       start;
    md_issue_t  issue;
    logic       busy;
    logic       valid;
    md_result_t result;

    int         cyc = 0;
    word_t      lcg_state = 32'd99529;
    md_result_t exp_q[$];
    string      name_q[$];
    int         start_q[$];
    word_t      bound_vals[5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    md_unit DUT (.clk(clk), .rst(rst), .start(start), .issue(issue),
                 .busy(busy), .valid(valid), .result(result));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // --------------------
    // reference model
    // --------------------

    function automatic word_t ref_rd_v(md_funct3_t f3, word_t a, word_t b);
        longint      sa, sb, ua, ub;
        logic [63:0] p;
        logic        ovf;
        sa  = $signed(a);
        sb  = $signed(b);
        ua  = {32'h0, a};
        ub  = {32'h0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (f3)
            mult_div_f3_mul:    p = sa * sb;
            mult_div_f3_mulh:   p = (sa * sb) >> 32;
            mult_div_f3_mulhsu: p = (sa * ub) >> 32;
            mult_div_f3_mulhu:  p = (ua * ub) >> 32;
            mult_div_f3_div:    p = (b == 0) ? -1 : ovf ? sa : sa / sb;
            mult_div_f3_divu:   p = (b == 0) ? -1 : ua / ub;
            mult_div_f3_rem:    p = (b == 0) ? sa : ovf ? 0 : sa % sb;
            mult_div_f3_remu:   p = (b == 0) ? ua : ua % ub;
            default:            p = '0;
        endcase
        return p[31:0];
    endfunction

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // mostly full-range values, with boundary values and small signed ones mixed in.
    function automatic word_t pick_operand();
        word_t r;
        r = lcg_next();
        if (r[31:29] == 3'd0) return bound_vals[r[20:18] % 5];
        if (r[31:29] == 3'd1) return {{24{r[7]}}, r[7:0]};
        return lcg_next();
    endfunction

    // --------------------
    // checks
    // --------------------

    task automatic check_result(string name, md_result_t exp, md_result_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected tag %0d rd_v %h, actual tag %0d rd_v %h",
                     name, exp.rd_tag, exp.rd_v, act.rd_tag, act.rd_v);
            $display("Test failed");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_latency(string name, int exp, int act);
        if (act != exp) begin
            $display("ERROR %s: expected latency %0d, actual latency %0d", name, exp, act);
            $display("Test failed");
            $fatal(1, "latency mismatch");
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            $display("Test failed");
            $fatal(1, "status mismatch");
        end
    endtask

    // --------------------
    // stimulus
    // --------------------

    task automatic wait_idle();
        @(negedge clk);
        while (busy) @(negedge clk);
    endtask

    task automatic send_op(string name, md_funct3_t f3, word_t a, word_t b, tag_t tag);
        md_issue_t  iss;
        md_result_t exp;
        iss.decode_info.funct3 = f3;
        iss.decode_info.rd_tag = tag;
        iss.rs1_v  = a;
        iss.rs2_v  = b;
        exp.rd_tag = tag;
        exp.rd_v   = ref_rd_v(f3, a, b);
        wait_idle();
        @(posedge clk);
        start <= 1'b1;
        issue <= iss;
        exp_q.push_back(exp);
        name_q.push_back(name);
        start_q.push_back(cyc + 1); // the counter steps into the start cycle at this edge.
        @(posedge clk);
        start <= 1'b0;
        issue <= md_issue_t'(~iss); // the unit has to work from its own copy now.
    endtask

    // every operation over every pair of boundary values, zero divisors and min / -1 included.
    task automatic edge_tests();
        md_funct3_t f3;
        for (int f = 0; f < 8; f++) begin
            f3 = md_funct3_t'(f);
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    send_op($sformatf("edge %s %h %h", f3.name(), bound_vals[i], bound_vals[j]),
                            f3, bound_vals[i], bound_vals[j], tag_t'(f * 25 + i * 5 + j));
                end
            end
        end
    endtask

    task automatic random_tests();
        word_t      r;
        word_t      a;
        word_t      b;
        md_funct3_t f3;
        for (int i = 0; i < N_RANDOM; i++) begin
            r  = lcg_next();
            f3 = md_funct3_t'(r[30:28]);
            a  = pick_operand();
            b  = pick_operand();
            send_op($sformatf("random %0d %s", i, f3.name()), f3, a, b, tag_t'(r[21:16]));
        end
    endtask

    task automatic dropped_start_test();
        md_issue_t extra;
        send_op("dropped start", mult_div_f3_divu, 32'hdead_beef, 32'h0000_1234, tag_t'(42));
        extra.decode_info.funct3 = mult_div_f3_mul;
        extra.decode_info.rd_tag = tag_t'(13);
        extra.rs1_v = 32'd7;
        extra.rs2_v = 32'd9;
        repeat (3) @(posedge clk);
        start <= 1'b1;
        issue <= extra;
        @(posedge clk);
        start <= 1'b0;
        wait_idle();
        repeat (LATENCY + 6) @(negedge clk); // a second result would show up in here.
    endtask

    // --------------------
    // compare and watchdog
    // --------------------

    initial begin : compare_results
        md_result_t exp;
        string      name;
        int         started;
        forever begin
            @(negedge clk);
            if (!rst && valid && exp_q.size() == 0) begin
                $display("valid strobe with no operation outstanding, tag %0d", result.rd_tag);
                $display("Test failed");
                $fatal(1, "unexpected result");
            end else if (!rst && valid) begin
                exp     = exp_q.pop_front();
                name    = name_q.pop_front();
                started = start_q.pop_front();
                check_result(name, exp, result);
                check_latency(name, LATENCY, cyc - started);
            end
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + N_OPS * 40) @(posedge clk);
        $display("timeout: the run took longer than %0d cycles", RESET_CYCLES + N_OPS * 40);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst   = 1'b1;
        start = 1'b0;
        issue = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_flag("idle after reset valid", 1'b0, valid);
            check_flag("idle after reset busy", 1'b0, busy);
        end
        edge_tests();
        random_tests();
        dropped_start_test();
        wait_idle();
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d results never came back", exp_q.size());
            $display("Test failed");
            $fatal(1, "missing results");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- tb/md_unit_assertions.sv
`timescale 1ns/10ps

module md_unit_assertions (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic valid
);

    // --------------------
    // result strobe
    // --------------------

    valid_one_cycle: assert property (@(posedge clk) disable iff (rst) valid |=> !valid)
        else $error("valid stayed high for more than one cycle");

    // busy is high in every state but idle.
    valid_not_idle: assert property (@(posedge clk) disable iff (rst) valid |-> busy)
        else $error("valid raised while the unit was idle");

    busy_after_valid: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> $past(valid))
        else $error("busy dropped without a result strobe");

endmodule

bind md_unit md_unit_assertions u_assertions (.clk(clk), .rst(rst), .busy(busy), .valid(valid));

//--- src/md_unit.sv
`timescale 1ns/10ps
`include "md_macros.svh"

module md_unit import md_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  md_issue_t   issue,
    output logic        busy,
    output logic        valid,
    output md_result_t  result
);

    logic                   load;
    logic                   step_en;
    logic                   last;
    logic [`MD_XLEN-1:0]    mul_word;
    logic [`MD_XLEN-1:0]    div_word;

    // --------------------
    // sequencing
    // --------------------

    md_control u_control (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .issue    (issue),
        .mul_word (mul_word),
        .div_word (div_word),
        .last     (last),
        .load     (load),
        .step_en  (step_en),
        .busy     (busy),
        .valid    (valid),
        .result   (result)
    );

    md_step_counter u_counter (
        .clk  (clk),
        .rst  (rst),
        .load (load),
        .en   (step_en),
        .last (last)
    );

    // --------------------
    // datapaths
    // --------------------

    // both run on every operation. control picks the one that matters.
    md_divider u_divider (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .step_en (step_en),
        .issue   (issue),
        .word    (div_word)
    );

    md_multiplier u_multiplier (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .step_en (step_en),
        .issue   (issue),
        .word    (mul_word)
    );

endmodule

//--- src/md_multiplier.sv
`timescale 1ns/10ps
`include "md_macros.svh"

module md_multiplier import md_pkg::*, rv32m_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  logic                step_en,
    input  md_issue_t           issue,
    output logic [`MD_XLEN-1:0] word
);

    localparam int W = `MD_XLEN;

    md_funct3_t     f3;
    logic           a_signed, b_signed;
    logic           sign_a, sign_b;
    logic [W-1:0]   mag_a, mag_b;

    logic           neg_q, want_lo;
    logic [W-1:0]   mcand_q;
    md_product_u    acc_q;
    md_product_u    fixed;
    logic [W:0]     sum;

    // --------------------
    // operand decode
    // --------------------

    // mulhsu keeps rs2 unsigned, mulhu keeps both unsigned.
    always_comb begin
        f3       = issue.decode_info.funct3;
        a_signed = (f3 != mult_div_f3_mulhu);
        b_signed = (f3 == mult_div_f3_mul) || (f3 == mult_div_f3_mulh);
        sign_a   = a_signed && issue.rs1_v[W-1];
        sign_b   = b_signed && issue.rs2_v[W-1];
        mag_a    = sign_a ? -issue.rs1_v : issue.rs1_v;
        mag_b    = sign_b ? -issue.rs2_v : issue.rs2_v;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            neg_q   <= 1'b0;
            want_lo <= 1'b0;
        end else if (load) begin
            neg_q   <= sign_a ^ sign_b;
            want_lo <= (f3 == mult_div_f3_mul);
        end
    end

    // --------------------
    // shift-add iteration
    // --------------------

    // the multiplier sits in the low word and is shifted out as the product fills in.
    assign sum = {1'b0, acc_q.words.hi} + (acc_q.words.lo[0] ? {1'b0, mcand_q} : '0);

    always_ff @(posedge clk) begin
        if (load) begin
            mcand_q     <= mag_a;
            acc_q.whole <= {{W{1'b0}}, mag_b};
        end else if (step_en) begin
            acc_q.whole <= {sum, acc_q.words.lo[W-1:1]};
        end
    end

    always_comb begin
        fixed.whole = neg_q ? -acc_q.whole : acc_q.whole;
        word        = want_lo ? fixed.words.lo : fixed.words.hi;
    end

endmodule

//--- src/md_divider.sv
`timescale 1ns/10ps
`include "md_macros.svh"

module md_divider import md_pkg::*, rv32m_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  logic                step_en,
    input  md_issue_t           issue,
    output logic [`MD_XLEN-1:0] word
);

    localparam int W = `MD_XLEN;

    md_funct3_t     f3;
    logic           is_signed;
    logic           sign_a, sign_b;
    logic [W-1:0]   mag_a, mag_b;

    logic           neg_q, neg_r, div_zero, ovf, want_rem;
    logic [W-1:0]   rem_q, quo_q, dvs_q, dvd_raw_q;

    logic [W:0]     shifted;
    logic [W+1:0]   diff;
    logic [W-1:0]   q_fix, r_fix;

    // --------------------
    // operand decode
    // --------------------

    always_comb begin
        f3        = issue.decode_info.funct3;
        is_signed = (f3 == mult_div_f3_div) || (f3 == mult_div_f3_rem);
        sign_a    = is_signed && issue.rs1_v[W-1];
        sign_b    = is_signed && issue.rs2_v[W-1];
        mag_a     = sign_a ? -issue.rs1_v : issue.rs1_v;
        mag_b     = sign_b ? -issue.rs2_v : issue.rs2_v;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            neg_q    <= 1'b0;
            neg_r    <= 1'b0;
            div_zero <= 1'b0;
            ovf      <= 1'b0;
            want_rem <= 1'b0;
        end else if (load) begin
            neg_q    <= sign_a ^ sign_b;
            neg_r    <= sign_a; // remainder takes the dividend's sign.
            div_zero <= (issue.rs2_v == '0);
            ovf      <= is_signed && (issue.rs1_v == {1'b1, {(W-1){1'b0}}})
                        && (issue.rs2_v == '1);
            want_rem <= f3[1];
        end
    end

    // --------------------
    // restoring iteration
    // --------------------

    always_comb begin
        shifted = {rem_q, quo_q[W-1]};
        diff    = {1'b0, shifted} - {2'b00, dvs_q};
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rem_q     <= '0;
            quo_q     <= mag_a;
            dvs_q     <= mag_b;
            dvd_raw_q <= issue.rs1_v;
        end else if (step_en) begin
            if (!diff[W+1]) begin
                rem_q <= diff[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end else begin
                rem_q <= shifted[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b0};
            end
        end
    end

    // sign fix, then the two RISC-V special cases override.
    always_comb begin
        q_fix = neg_q ? -quo_q : quo_q;
        r_fix = neg_r ? -rem_q : rem_q;
        if (div_zero) begin
            word = want_rem ? dvd_raw_q : '1;
        end else if (ovf) begin
            word = want_rem ? '0 : {1'b1, {(W-1){1'b0}}};
        end else begin
            word = want_rem ? r_fix : q_fix;
        end
    end

endmodule

//--- src/md_step_counter.sv
`timescale 1ns/10ps
`include "md_macros.svh"

module md_step_counter (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic en,
    output logic last
);

    localparam int CNT_W = $clog2(`MD_STEPS + 1);

    logic [CNT_W-1:0] count;

    // counts the remaining iterations, one per enabled cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= CNT_W'(`MD_STEPS);
        end else if (en && count != '0) begin
            count <= count - 1'b1;
        end
    end

    // high during the step that leaves the count at zero.
    assign last = en && (count == CNT_W'(1));

endmodule

//--- src/md_control.sv
`timescale 1ns/10ps
`include "md_macros.svh"

module md_control import md_pkg::*, rv32m_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  md_issue_t           issue,
    input  logic [`MD_XLEN-1:0] mul_word,
    input  logic [`MD_XLEN-1:0] div_word,
    input  logic                last,
    output logic                load,
    output logic                step_en,
    output logic                busy,
    output logic                valid,
    output md_result_t          result
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } state_t;

    state_t         state;
    decode_info_t   info_q;
    md_class_t      op_class;

    assign op_class = md_class_of(info_q.funct3);

    assign load    = start && (state == st_idle); // a start while busy is simply dropped.
    assign step_en = (state == st_run);
    assign busy    = (state != st_idle);

    // --------------------
    // sequencing
    // --------------------

    // done takes two cycles. the first captures the word, the second shows valid.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            valid <= 1'b0;
        end else begin
            unique case (state)
                st_idle: begin
                    if (start) state <= st_run;
                end
                st_run: begin
                    if (last) state <= st_done;
                end
                st_done: begin
                    if (!valid) begin
                        valid <= 1'b1;
                    end else begin
                        valid <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // --------------------
    // payload
    // --------------------

    always_ff @(posedge clk) begin
        if (load) info_q <= issue.decode_info;
        if (state == st_done && !valid) begin
            result.rd_tag <= info_q.rd_tag;
            result.rd_v   <= (op_class == md_class_div) ? div_word : mul_word;
        end
    end

endmodule

//--- src/md_pkg.sv
`include "md_macros.svh"

package md_pkg;

    // --------------------
    // issue and result
    // --------------------

    typedef struct packed {
        rv32m_pkg::decode_info_t    decode_info;
        logic [`MD_XLEN-1:0]        rs1_v;
        logic [`MD_XLEN-1:0]        rs2_v;
    } md_issue_t;

    typedef struct packed {
        logic [`MD_PHYS_REG_BITS-1:0]   rd_tag;
        logic [`MD_XLEN-1:0]            rd_v;
    } md_result_t;

    // which datapath produces the answer.
    typedef enum logic {
        md_class_mul = 1'b0,
        md_class_div = 1'b1
    } md_class_t;

    // top funct3 bit splits the M extension into its two halves.
    function automatic md_class_t md_class_of(rv32m_pkg::md_funct3_t f3);
        return f3[2] ? md_class_div : md_class_mul;
    endfunction

    // --------------------
    // product accumulator
    // --------------------

    typedef struct packed {
        logic [`MD_XLEN-1:0] hi;
        logic [`MD_XLEN-1:0] lo;
    } md_words_t;

    // negated as a whole, picked apart as words.
    typedef union packed {
        logic [2*`MD_XLEN-1:0]  whole;
        md_words_t              words;
    } md_product_u;

endpackage

//--- src/rv32m_pkg.sv
`include "md_macros.svh"

package rv32m_pkg;

    // --------------------
    // M extension funct3
    // --------------------

    typedef enum logic [2:0] {
        mult_div_f3_mul    = 3'b000,
        mult_div_f3_mulh   = 3'b001,
        mult_div_f3_mulhsu = 3'b010,
        mult_div_f3_mulhu  = 3'b011,
        mult_div_f3_div    = 3'b100,
        mult_div_f3_divu   = 3'b101,
        mult_div_f3_rem    = 3'b110,
        mult_div_f3_remu   = 3'b111
    } md_funct3_t;

    // --------------------
    // decoded instruction
    // --------------------

    // what the issue stage hands over besides the operand values.
    // the tag comes back unchanged with the result.
    typedef struct packed {
        md_funct3_t                         funct3;
        logic [`MD_PHYS_REG_BITS-1:0]       rd_tag;
    } decode_info_t;

endpackage

//--- src/md_macros.svh
`ifndef MD_MACROS_SVH
`define MD_MACROS_SVH

// --------------------
// datapath sizing
// --------------------

// operand and result width of the unit.
`define MD_XLEN 32

// one iteration per operand bit for both datapaths.
`define MD_STEPS `MD_XLEN

// --------------------
// rename sizing
// --------------------

`define MD_PHYS_REG_BITS 6 // matches the physical register file depth.

`endif
